// ==== files.f ====
src/alu_pkg.sv
src/alu_simple.sv
src/mul_booth2.sv
src/div_radix2.sv
src/alu.sv
verification/alu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module alu_tb -Mdir obj_dir -o alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/alu_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
else
    exit 1
fi

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               in_valid,
    output logic               in_ready,
    input  alu_pkg::alu_req_t  in_req,

    output logic               out_valid,
    input  logic               out_ready,
    output alu_pkg::alu_resp_t out_resp
);
    import alu_pkg::*;

    logic              is_mul;
    logic              is_div;
    logic              mul_sign;
    logic              div_sign;
    logic              fire;
    logic              load_fast;   // single-cycle or multiply result goes out next cycle
    logic              div_start;

    logic [data_w-1:0] simple_result;
    logic              simple_ovf;
    logic [res_w-1:0]  mul_product;
    logic              div_busy;
    logic              div_done;
    logic [res_w-1:0]  div_result;
    alu_resp_t         fast_resp;

    // opcode decode
    always_comb begin
        is_mul   = (in_req.op == alu_mult) | (in_req.op == alu_multu);
        is_div   = (in_req.op == alu_div) | (in_req.op == alu_divu);
        mul_sign = (in_req.op == alu_mult);
        div_sign = (in_req.op == alu_div);
    end

    // no new work while dividing or while the output is stuck
    assign in_ready  = ~div_busy & (~out_valid | out_ready);
    assign fire      = in_valid & in_ready;
    assign load_fast = fire & ~is_div;
    assign div_start = fire & is_div;

    alu_simple u_simple (
        .req      (in_req),
        .result   (simple_result),
        .overflow (simple_ovf)
    );

    mul_booth2 u_mul (
        .a       (in_req.src_a),
        .b       (in_req.src_b),
        .sign    (mul_sign),
        .product (mul_product)
    );

    div_radix2 u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (div_start),
        .a      (in_req.src_a),
        .b      (in_req.src_b),
        .sign   (div_sign),
        .busy   (div_busy),
        .done   (div_done),
        .result (div_result)
    );

    always_comb begin
        fast_resp.result   = is_mul ? mul_product : {{data_w{1'b0}}, simple_result};
        fast_resp.overflow = simple_ovf;   // already zero for mult codes
    end

    // output valid flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_fast || div_done) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;   // drained, nothing new behind it
        end
    end

    // response payload, held while out_valid waits for out_ready
    always_ff @(posedge clk) begin
        if (load_fast) begin
            out_resp <= fast_resp;
        end else if (div_done) begin
            out_resp.result   <= div_result;
            out_resp.overflow <= 1'b0;
        end
    end

endmodule

// ==== src/alu_pkg.sv ====
package alu_pkg;

    localparam int data_w    = 32;
    localparam int res_w     = 2 * data_w;   // {hi, lo} or {rem, quo}
    localparam int div_steps = data_w;       // one quotient bit per step

    // booth multiplier works on operands widened to an even length
    localparam int mul_ext_w = data_w + 2;
    localparam int mul_pp_n  = mul_ext_w / 2;

    typedef enum logic [4:0] {
        alu_and    = 5'd0,
        alu_or     = 5'd1,
        alu_nor    = 5'd2,
        alu_xor    = 5'd3,
        alu_xnor   = 5'd4,
        alu_add    = 5'd5,
        alu_addu   = 5'd6,
        alu_sub    = 5'd7,
        alu_subu   = 5'd8,
        alu_gtz    = 5'd9,
        alu_gez    = 5'd10,
        alu_ltz    = 5'd11,
        alu_lez    = 5'd12,
        alu_slt    = 5'd13,
        alu_sltu   = 5'd14,
        alu_sll    = 5'd15,
        alu_srl    = 5'd16,
        alu_sra    = 5'd17,
        alu_sll_sa = 5'd18,
        alu_srl_sa = 5'd19,
        alu_sra_sa = 5'd20,
        alu_mthi   = 5'd21,
        alu_mtlo   = 5'd22,
        alu_lui    = 5'd23,
        alu_mult   = 5'd24,
        alu_multu  = 5'd25,
        alu_div    = 5'd26,
        alu_divu   = 5'd27
    } alu_op_t;   // codes 28..31 are unused

    typedef struct packed {
        alu_op_t           op;
        logic [data_w-1:0] src_a;
        logic [data_w-1:0] src_b;
        logic [4:0]        sa;      // immediate shift amount
    } alu_req_t;

    typedef struct packed {
        logic [res_w-1:0] result;
        logic             overflow;
    } alu_resp_t;

endpackage

// ==== src/alu_simple.sv ====
`timescale 1ns/1ps

module alu_simple (
    input  alu_pkg::alu_req_t         req,
    output logic [alu_pkg::data_w-1:0] result,
    output logic                       overflow
);
    import alu_pkg::*;

    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic              a_msb;
    logic              b_msb;
    logic              a_zero;

    assign sum    = req.src_a + req.src_b;
    assign diff   = req.src_a - req.src_b;
    assign a_msb  = req.src_a[data_w-1];
    assign b_msb  = req.src_b[data_w-1];
    assign a_zero = ~(|req.src_a);

    always_comb begin
        case (req.op)
            alu_and:    result = req.src_a & req.src_b;
            alu_or:     result = req.src_a | req.src_b;
            alu_nor:    result = ~(req.src_a | req.src_b);
            alu_xor:    result = req.src_a ^ req.src_b;
            alu_xnor:   result = ~(req.src_a ^ req.src_b);

            alu_add,
            alu_addu:   result = sum;
            alu_sub,
            alu_subu:   result = diff;

            // branch style compares against zero
            alu_gtz:    result = {{(data_w-1){1'b0}}, ~a_msb & ~a_zero};
            alu_gez:    result = {{(data_w-1){1'b0}}, ~a_msb};
            alu_ltz:    result = {{(data_w-1){1'b0}}, a_msb};
            alu_lez:    result = {{(data_w-1){1'b0}}, a_msb | a_zero};

            alu_slt:    result = {{(data_w-1){1'b0}}, $signed(req.src_a) < $signed(req.src_b)};
            alu_sltu:   result = {{(data_w-1){1'b0}}, req.src_a < req.src_b};

            // variable shifts take the amount from src_a
            alu_sll:    result = req.src_b << req.src_a[4:0];
            alu_srl:    result = req.src_b >> req.src_a[4:0];
            alu_sra:    result = $signed(req.src_b) >>> req.src_a[4:0];

            alu_sll_sa: result = req.src_b << req.sa;
            alu_srl_sa: result = req.src_b >> req.sa;
            alu_sra_sa: result = $signed(req.src_b) >>> req.sa;

            alu_mthi,
            alu_mtlo:   result = req.src_a;   // hi/lo write data
            alu_lui:    result = {req.src_b[15:0], 16'b0};

            // handled by the multiplier and divider
            alu_mult,
            alu_multu,
            alu_div,
            alu_divu:   result = '0;
            default:    result = '0;
        endcase
    end

    // signed overflow, only the trapping forms report it
    always_comb begin
        case (req.op)
            alu_add:  overflow = (a_msb == b_msb) && (sum[data_w-1] != a_msb);
            alu_sub:  overflow = (a_msb != b_msb) && (diff[data_w-1] != a_msb);
            default:  overflow = 1'b0;
        endcase
    end

endmodule

// ==== src/div_radix2.sv ====
`timescale 1ns/1ps

module div_radix2 (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [alu_pkg::data_w-1:0] a,        // dividend
    input  logic [alu_pkg::data_w-1:0] b,        // divisor
    input  logic                       sign,     // 1 for signed division
    output logic                       busy,
    output logic                       done,
    output logic [alu_pkg::res_w-1:0]  result    // {remainder, quotient}
);
    import alu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix
    } div_state_t;

    div_state_t                   state;
    logic [$clog2(div_steps)-1:0] step;
    logic [data_w-1:0]            rem;
    logic [data_w-1:0]            quo;      // holds dividend bits, fills with quotient
    logic [data_w-1:0]            dvs;
    logic                         neg_q;
    logic                         neg_r;
    logic                         a_neg;
    logic                         b_neg;
    logic                         load;
    logic [data_w:0]              partial;
    logic [data_w:0]              trial;
    logic                         fits;

    assign a_neg = sign & a[data_w-1];
    assign b_neg = sign & b[data_w-1];
    assign load  = start & (state == st_idle);

    // one restoring step: shift in the next dividend bit, try to subtract
    assign partial = {rem, quo[data_w-1]};
    assign trial   = partial - {1'b0, dvs};
    assign fits    = partial >= {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (load) begin
                        state <= st_run;
                        step  <= '0;
                    end
                end
                st_run: begin
                    step <= step + 1'b1;
                    if (step == ($clog2(div_steps))'(div_steps - 1)) begin
                        state <= st_fix;
                    end
                end
                st_fix:  state <= st_idle;   // result valid this cycle
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem   <= '0;
            quo   <= a_neg ? -a : a;
            dvs   <= b_neg ? -b : b;
            // divide by zero keeps the all ones quotient as is
            neg_q <= (a_neg ^ b_neg) & (|b);
            neg_r <= a_neg;
        end else if (state == st_run) begin
            rem <= fits ? trial[data_w-1:0] : partial[data_w-1:0];
            quo <= {quo[data_w-2:0], fits};
        end
    end

    assign busy = (state != st_idle);
    assign done = (state == st_fix);

    // remainder follows the dividend sign, quotient truncates toward zero
    // regs are quiet in idle, so this holds until the next start
    assign result = {neg_r ? -rem : rem, neg_q ? -quo : quo};

endmodule

// ==== src/mul_booth2.sv ====
`timescale 1ns/1ps

module mul_booth2 (
    input  logic [alu_pkg::data_w-1:0] a,
    input  logic [alu_pkg::data_w-1:0] b,
    input  logic                       sign,      // 1 for signed operands
    output logic [alu_pkg::res_w-1:0]  product
);
    import alu_pkg::*;

    logic [mul_ext_w-1:0] a_ext;
    logic [mul_ext_w-1:0] b_ext;
    logic [mul_ext_w:0]   b_code;   // multiplier with the implied zero below bit 0
    logic [res_w-1:0]     a_wide;
    logic [res_w-1:0]     pp [mul_pp_n];

    // unsigned operands get two zero bits so they stay positive
    assign a_ext  = {{2{sign & a[data_w-1]}}, a};
    assign b_ext  = {{2{sign & b[data_w-1]}}, b};
    assign b_code = {b_ext, 1'b0};
    assign a_wide = {{(res_w-mul_ext_w){a_ext[mul_ext_w-1]}}, a_ext};

    for (genvar i = 0; i < mul_pp_n; i++) begin : g_pp
        logic [2:0]       code;
        logic             sel_one;
        logic             sel_two;
        logic             sel_neg;
        logic [res_w-1:0] mag;

        assign code = b_code[2*i+2 -: 3];

        // booth digit in {-2, -1, 0, +1, +2}
        assign sel_one = code[1] ^ code[0];
        assign sel_two = (code == 3'b011) | (code == 3'b100);
        assign sel_neg = code[2] & ~(code[1] & code[0]);

        assign mag = sel_one ? a_wide : (sel_two ? (a_wide << 1) : '0);

        // weight of digit i is 4**i
        assign pp[i] = (sel_neg ? -mag : mag) << (2 * i);
    end

    always_comb begin
        product = '0;
        for (int i = 0; i < mul_pp_n; i++) begin
            product = product + pp[i];   // wraps mod 2**64, which is what we want
        end
    end

endmodule

// ==== verification/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;
    import alu_pkg::*;

    localparam int op_budget  = 300;   // requests over all five tests, rounded up
    localparam int cyc_per_op = 40;    // a division plus back-pressure slack
    localparam int max_cycles = (op_budget * cyc_per_op * 5) / 4;
    localparam int div_lat    = div_steps + 2;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    alu_req_t  in_req;
    logic      out_valid;
    logic      out_ready;
    alu_resp_t out_resp;

    alu_resp_t exp_q[$];               // expected responses in issue order
    integer    seed = 78676;
    int        cyc = 0;
    int        errors = 0;             // monitor checks
    int        seq_errors = 0;         // end of run checks
    int        n_req = 0;
    int        n_resp = 0;
    int        test_no = 0;
    int        err_mark = 0;
    int        div_acc_cyc = 0;
    logic      bp_on = 1'b0;
    logic      stalled = 1'b0;
    logic      fast_pending = 1'b0;
    logic      div_pending = 1'b0;
    logic      first_cycle = 1'b1;
    alu_resp_t held_resp = '0;

    alu DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_resp  (out_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // expected response, straight from the result rules
    function automatic alu_resp_t model(input alu_req_t r);
        alu_resp_t          resp;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        lo;
        logic [32:0]        wide;
        logic signed [63:0] num;
        logic signed [63:0] den;
        a    = r.src_a;
        b    = r.src_b;
        lo   = '0;
        wide = '0;
        resp = '0;
        case (r.op)
            alu_and:            lo = a & b;
            alu_or:             lo = a | b;
            alu_nor:            lo = ~(a | b);
            alu_xor:            lo = a ^ b;
            alu_xnor:           lo = ~(a ^ b);
            alu_add, alu_addu:  lo = a + b;
            alu_sub, alu_subu:  lo = a - b;
            alu_gtz:            lo = ($signed(a) > 0) ? 32'd1 : 32'd0;
            alu_gez:            lo = ($signed(a) >= 0) ? 32'd1 : 32'd0;
            alu_ltz:            lo = ($signed(a) < 0) ? 32'd1 : 32'd0;
            alu_lez:            lo = ($signed(a) <= 0) ? 32'd1 : 32'd0;
            alu_slt:            lo = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:           lo = (a < b) ? 32'd1 : 32'd0;
            alu_sll:            lo = b << a[4:0];
            alu_srl:            lo = b >> a[4:0];
            alu_sra:            lo = $signed(b) >>> a[4:0];
            alu_sll_sa:         lo = b << r.sa;
            alu_srl_sa:         lo = b >> r.sa;
            alu_sra_sa:         lo = $signed(b) >>> r.sa;
            alu_mthi, alu_mtlo: lo = a;
            alu_lui:            lo = {b[15:0], 16'h0000};
            default:            lo = '0;
        endcase
        resp.result = {32'h0, lo};
        case (r.op)
            alu_mult:  resp.result = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            alu_multu: resp.result = {32'h0, a} * {32'h0, b};
            alu_div, alu_divu: begin
                num = (r.op == alu_div) ? {{32{a[31]}}, a} : {32'h0, a};
                den = (r.op == alu_div) ? {{32{b[31]}}, b} : {32'h0, b};
                if (b == 32'h0) begin
                    resp.result = {a, 32'hffff_ffff};
                end else begin
                    resp.result = {32'(num % den), 32'(num / den)};
                end
            end
            alu_add:   wide = {a[31], a} + {b[31], b};   // 33 bit signed sum
            alu_sub:   wide = {a[31], a} - {b[31], b};
            default:   ;
        endcase
        resp.overflow = wide[32] ^ wide[31];
        return resp;
    endfunction

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            default: return 32'h8000_0000;
        endcase
    endfunction

    // mostly random, corners about half the time
    function automatic logic [31:0] pick_operand();
        logic [31:0] w;
        w = rand_word();
        if (w[2]) begin
            return corner_value(int'(w[1:0]));
        end
        return rand_word();
    endfunction

    function automatic alu_req_t make_req(input alu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [4:0] sa);
        alu_req_t r;
        r.op    = op;
        r.src_a = a;
        r.src_b = b;
        r.sa    = sa;
        return r;
    endfunction

    task automatic mismatch(input string sig, input logic [64:0] exp, input logic [64:0] act);
        $display("FAILED %s expected %h got %h", sig, exp, act);
        errors++;
    endtask

    task automatic tick();
        logic [31:0] w;
        @(posedge clk);
        if (bp_on) begin
            w = rand_word();
            out_ready <= w[0] | w[1];   // ready about three cycles in four
        end
    endtask

    task automatic send(input alu_req_t r);
        in_valid <= 1'b1;
        in_req   <= r;
        tick();
        while (!in_ready) tick();
    endtask

    task automatic end_test(input string name);
        int errs;
        in_valid <= 1'b0;
        do begin
            tick();
            @(negedge clk);
        end while (exp_q.size() != 0 || out_valid);
        errs = errors + seq_errors - err_mark;
        test_no++;
        if (errs == 0) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            $display("test %0d %s: %0d errors", test_no, name, errs);
        end
        err_mark = errors + seq_errors;
        @(posedge clk);
        out_ready <= 1'b1;
    endtask

    task automatic div_pair(input logic [31:0] a, input logic [31:0] b);
        send(make_req(alu_div, a, b, 5'd0));
        send(make_req(alu_divu, a, b, 5'd0));
    endtask

    always @(posedge clk) begin
        alu_resp_t exp_resp;
        logic      is_div_req;
        cyc = cyc + 1;
        if (cyc >= max_cycles) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cyc);
            $display("=== FAIL ===");
            $finish;
        end else if (rst_n) begin
            if (first_cycle) begin
                assert (!out_valid) else mismatch("out_valid", 65'd0, 65'(out_valid));
                assert (in_ready) else mismatch("in_ready", 65'd1, 65'(in_ready));
                first_cycle = 1'b0;
            end
            if (stalled) begin
                assert (out_valid) else mismatch("out_valid", 65'd1, 65'(out_valid));
                assert (out_resp == held_resp) else mismatch("out_resp", held_resp, out_resp);
            end
            assert (!(out_valid && !out_ready && in_ready)) else begin
                $display("in_ready is high while the response waits for out_ready");
                errors++;
            end
            if (fast_pending) begin
                assert (out_valid) else mismatch("out_valid", 65'd1, 65'(out_valid));
            end
            if (div_pending && !out_valid) begin
                assert (!in_ready) else mismatch("in_ready", 65'd0, 65'(in_ready));
            end
            if (div_pending && out_valid) begin
                assert (cyc - div_acc_cyc == div_lat) else begin
                    $display("division answered after %0d cycles instead of %0d",
                             cyc - div_acc_cyc, div_lat);
                    errors++;
                end
                div_pending = 1'b0;
            end
            if (out_valid && out_ready) begin
                n_resp++;   // every accepted response, expected or not
                assert (exp_q.size() != 0) else begin
                    $display("a response came out with no request behind it");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_resp = exp_q.pop_front();
                    assert (out_resp == exp_resp) else mismatch("out_resp", exp_resp, out_resp);
                end
            end
            is_div_req   = (in_req.op == alu_div) || (in_req.op == alu_divu);
            fast_pending = in_valid && in_ready && !is_div_req;
            if (in_valid && in_ready) begin
                exp_q.push_back(model(in_req));
                n_req++;
                if (is_div_req) begin
                    div_pending = 1'b1;
                    div_acc_cyc = cyc;
                end
            end
            stalled   = out_valid && !out_ready;
            held_resp = out_resp;
        end
    end

    initial begin
        logic [31:0] w;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // overflow corners at both ends of the signed range
        send(make_req(alu_add, 32'h7fff_ffff, 32'h0000_0001, 5'd0));
        send(make_req(alu_sub, 32'h8000_0000, 32'h0000_0001, 5'd0));
        send(make_req(alu_mult, 32'hffff_fffd, 32'h0000_0007, 5'd0));
        send(make_req(alu_add, 32'h8000_0000, 32'hffff_ffff, 5'd0));
        send(make_req(alu_sub, 32'h7fff_ffff, 32'hffff_ffff, 5'd0));
        send(make_req(alu_add, 32'h7fff_fffe, 32'h0000_0001, 5'd0));
        send(make_req(alu_sub, 32'h8000_0000, 32'h8000_0000, 5'd0));
        end_test("reset, add/sub overflow, ordering");

        for (int k = 0; k < 24; k++) begin
            send(make_req(alu_op_t'(k[4:0]), 32'h0000_0000, 32'h1234_abcd, 5'd31));
            send(make_req(alu_op_t'(k[4:0]), 32'hffff_fff3, 32'h80f0_1234, 5'd4));
            send(make_req(alu_op_t'(k[4:0]), 32'h0000_0011, 32'h7fff_0f0f, 5'd0));
        end
        repeat (60) begin
            w = rand_word();
            send(make_req(alu_op_t'(w[4:0] % 5'd24), pick_operand(), pick_operand(), w[9:5]));
        end
        for (int k = 28; k < 32; k++) begin
            send(make_req(alu_op_t'(k[4:0]), 32'hdead_beef, 32'h0bad_f00d, 5'd3));
        end
        end_test("single-cycle opcodes");

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                send(make_req(alu_mult, corner_value(i), corner_value(j), 5'd0));
                send(make_req(alu_multu, corner_value(i), corner_value(j), 5'd0));
            end
        end
        repeat (10) begin
            send(make_req(alu_mult, rand_word(), rand_word(), 5'd0));
            send(make_req(alu_multu, rand_word(), rand_word(), 5'd0));
        end
        end_test("mult and multu");

        div_pair(32'd100, 32'd7);
        div_pair(-32'sd100, 32'd7);
        div_pair(32'd100, -32'sd7);
        div_pair(-32'sd100, -32'sd7);
        div_pair(32'd5, 32'd0);
        div_pair(-32'sd5, 32'd0);
        div_pair(32'h8000_0000, 32'hffff_ffff);
        div_pair(32'd7, 32'd100);
        repeat (6) begin
            div_pair(rand_word(), pick_operand());
        end
        end_test("div and divu");

        bp_on = 1'b1;
        repeat (60) begin
            w = rand_word();
            send(make_req(alu_op_t'(w[4:0] % 5'd28), pick_operand(), pick_operand(), w[9:5]));
        end
        end_test("random mix under back-pressure");
        bp_on = 1'b0;

        @(negedge clk);
        assert (n_resp == n_req) else begin
            $display("%0d responses came back for %0d requests", n_resp, n_req);
            seq_errors++;
        end
        $display("tests %0d, requests %0d, responses %0d, errors %0d",
                 test_no, n_req, n_resp, errors + seq_errors);
        if (errors + seq_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
